// File: source/mipsPkg.sv
/*
 * MIPS32 core definitions
 * opcodes, ALU operations, reset vector and the records carried
 * across each pipeline boundary
 */
`default_nettype none

package mipsPkg;

    localparam logic [31:0] resetVector = 32'hBFC0_0000;

    localparam logic [5:0] opSpecial = 6'h00;   // R-type, funct decides
    localparam logic [5:0] opBeq     = 6'h04;
    localparam logic [5:0] opBne     = 6'h05;
    localparam logic [5:0] opAddiu   = 6'h09;
    localparam logic [5:0] opOri     = 6'h0D;
    localparam logic [5:0] opLui     = 6'h0F;
    localparam logic [5:0] opLw      = 6'h23;
    localparam logic [5:0] opSw      = 6'h2B;

    localparam logic [5:0] fnSll  = 6'h00;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnSlt  = 6'h2A;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluSll,
        aluLui
    } aluOpT;

    typedef enum logic {
        wbAlu,
        wbMem
    } wbSelT;

    typedef struct packed {
        aluOpT aluOp;
        logic  aluSrcImm;       // operand B from imm32
        logic  shiftUsesShamt;
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  isBranch;
        logic  branchOnNe;      // BNE when set, BEQ otherwise
        wbSelT wbSel;
    } ctrlT;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instr;
    } ifIdT;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        ctrlT        ctrl;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  dst;
        logic [31:0] busA;
        logic [31:0] busB;
        logic [31:0] imm32;
        logic [4:0]  shamt;
    } idExT;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        regWrite;
        logic        memRead;
        logic        memWrite;
        logic [4:0]  dst;
        logic [31:0] aluOut;
        logic [31:0] storeData;
    } exMemT;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        regWrite;
        logic [4:0]  dst;
        logic [31:0] result;
    } memWbT;

    // bypass record for a register result
    typedef struct packed {
        logic        regWrite;
        logic [4:0]  dst;
        logic [31:0] value;
    } fwdT;

endpackage

`default_nettype wire

// File: source/fetchStage.sv
/*
 * Fetch stage
 * holds the program counter, picks the next PC and registers the
 * fetched word into IF/ID, with hold on stall and squash on branch
 */
`timescale 1ns/10ps
`default_nettype none

module fetchStage import mipsPkg::*; (
    input  wire logic        clk,
    input  wire logic        reset_i,
    input  wire logic        stall_i,
    input  wire logic        branchTaken_i,
    input  wire logic [31:0] branchTarget_i,
    output      logic [31:0] instAddr_o,
    input  wire logic [31:0] instData_i,
    output      ifIdT        ifId_o
);

    logic [31:0] pcQ;
    logic [31:0] pcNext;
    ifIdT        ifIdQ;

    always_comb begin
        if (branchTaken_i) begin
            pcNext = branchTarget_i;
        end else if (stall_i) begin
            pcNext = pcQ;       // load-use hold
        end else begin
            pcNext = pcQ + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pcQ <= resetVector;
            ifIdQ.valid <= 1'b0;
        end else begin
            pcQ <= pcNext;
            if (!stall_i) begin
                // word after the delay slot is dropped on a taken branch
                ifIdQ <= '{valid: ~branchTaken_i, pc: pcQ, instr: instData_i};
            end
        end
    end

    assign instAddr_o = pcQ;
    assign ifId_o     = ifIdQ;

endmodule

`default_nettype wire

// File: source/regFile.sv
/*
 * Register file
 * 32 x 32 bits, two read ports, one write port from write-back;
 * a write in the same cycle is seen by the read ports
 */
`timescale 1ns/10ps
`default_nettype none

module regFile import mipsPkg::*; (
    input  wire logic        clk,
    input  wire logic        reset_i,
    input  wire fwdT         wb_i,
    input  wire logic [4:0]  rsAddr_i,
    input  wire logic [4:0]  rtAddr_i,
    output      logic [31:0] rsData_o,
    output      logic [31:0] rtData_o
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (wb_i.regWrite && wb_i.dst != 5'd0) begin
            regs[wb_i.dst] <= wb_i.value;
        end
    end

    // $zero first, then the write-back bypass
    assign rsData_o = (rsAddr_i == 5'd0) ? 32'd0 :
                      (wb_i.regWrite && wb_i.dst == rsAddr_i) ? wb_i.value : regs[rsAddr_i];
    assign rtData_o = (rtAddr_i == 5'd0) ? 32'd0 :
                      (wb_i.regWrite && wb_i.dst == rtAddr_i) ? wb_i.value : regs[rtAddr_i];

endmodule

`default_nettype wire

// File: source/decodeStage.sv
/*
 * Decode stage
 * decodes the instruction into control, extends the immediate,
 * detects load-use hazards and registers ID/EX
 */
`timescale 1ns/10ps
`default_nettype none

module decodeStage import mipsPkg::*; (
    input  wire logic        clk,
    input  wire logic        reset_i,
    input  wire ifIdT        ifId_i,
    output      logic [4:0]  rsAddr_o,
    output      logic [4:0]  rtAddr_o,
    input  wire logic [31:0] rsData_i,
    input  wire logic [31:0] rtData_i,
    input  wire logic        branchTaken_i,
    output      logic        stall_o,
    output      idExT        idEx_o
);

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [4:0]  shamt;
    logic [15:0] imm;
    ctrlT        decCtrl;
    logic [4:0]  dst;
    logic        useRs;
    logic        useRt;
    logic        useRd;
    logic        zeroExt;
    logic        loadUse;
    idExT        idExD;
    idExT        idExQ;

    assign opcode = ifId_i.instr[31:26];
    assign rs     = ifId_i.instr[25:21];
    assign rt     = ifId_i.instr[20:16];
    assign rd     = ifId_i.instr[15:11];
    assign shamt  = ifId_i.instr[10:6];
    assign funct  = ifId_i.instr[5:0];
    assign imm    = ifId_i.instr[15:0];

    always_comb begin
        decCtrl = '0;
        decCtrl.aluOp = aluAdd;
        decCtrl.wbSel = wbAlu;
        useRs = 1'b0;
        useRt = 1'b0;
        useRd = 1'b0;
        zeroExt = 1'b0;
        case (opcode)
            opSpecial: begin
                useRs = 1'b1;
                useRt = 1'b1;
                useRd = 1'b1;
                decCtrl.regWrite = 1'b1;
                case (funct)
                    fnAddu: decCtrl.aluOp = aluAdd;
                    fnSubu: decCtrl.aluOp = aluSub;
                    fnAnd:  decCtrl.aluOp = aluAnd;
                    fnOr:   decCtrl.aluOp = aluOr;
                    fnSlt:  decCtrl.aluOp = aluSlt;
                    fnSll: begin
                        decCtrl.aluOp = aluSll;
                        decCtrl.shiftUsesShamt = 1'b1;
                        useRs = 1'b0;       // rs field unused by SLL
                    end
                    default: begin
                        decCtrl.regWrite = 1'b0;   // unknown funct, no-op
                        useRs = 1'b0;
                        useRt = 1'b0;
                    end
                endcase
            end
            opAddiu: begin
                decCtrl.aluSrcImm = 1'b1;
                decCtrl.regWrite = 1'b1;
                useRs = 1'b1;
            end
            opOri: begin
                decCtrl.aluOp = aluOr;
                decCtrl.aluSrcImm = 1'b1;
                decCtrl.regWrite = 1'b1;
                useRs = 1'b1;
                zeroExt = 1'b1;
            end
            opLui: begin
                decCtrl.aluOp = aluLui;
                decCtrl.aluSrcImm = 1'b1;
                decCtrl.regWrite = 1'b1;
            end
            opLw: begin
                decCtrl.aluSrcImm = 1'b1;
                decCtrl.regWrite = 1'b1;
                decCtrl.memRead = 1'b1;
                decCtrl.wbSel = wbMem;
                useRs = 1'b1;
            end
            opSw: begin
                decCtrl.aluSrcImm = 1'b1;
                decCtrl.memWrite = 1'b1;
                useRs = 1'b1;
                useRt = 1'b1;
            end
            opBeq, opBne: begin
                decCtrl.isBranch = 1'b1;
                decCtrl.branchOnNe = (opcode == opBne);
                useRs = 1'b1;
                useRt = 1'b1;
            end
            default: ;     // anything else is a no-op
        endcase
        dst = useRd ? rd : rt;
        if (dst == 5'd0) begin
            decCtrl.regWrite = 1'b0;    // $zero writes are dropped here
        end
    end

    // a branch resolving in execute is never a load
    assign loadUse = idExQ.valid && idExQ.ctrl.memRead && idExQ.dst != 5'd0 &&
                     ((useRs && rs == idExQ.dst) || (useRt && rt == idExQ.dst));
    assign stall_o = ifId_i.valid && loadUse && !branchTaken_i;

    assign idExD = '{
        valid: ifId_i.valid & ~stall_o,     // bubble while stalled
        pc:    ifId_i.pc,
        ctrl:  decCtrl,
        rs:    rs,
        rt:    rt,
        dst:   dst,
        busA:  rsData_i,
        busB:  rtData_i,
        imm32: zeroExt ? {16'd0, imm} : {{16{imm[15]}}, imm},
        shamt: shamt
    };

    always_ff @(posedge clk) begin
        if (reset_i) begin
            idExQ.valid <= 1'b0;
        end else begin
            idExQ <= idExD;
        end
    end

    assign rsAddr_o = rs;
    assign rtAddr_o = rt;
    assign idEx_o   = idExQ;

endmodule

`default_nettype wire

// File: source/executeStage.sv
/*
 * Execute stage
 * operand forwarding from memory and write-back, ALU, branch
 * resolution and the EX/MEM register
 */
`timescale 1ns/10ps
`default_nettype none

module executeStage import mipsPkg::*; (
    input  wire logic        clk,
    input  wire logic        reset_i,
    input  wire idExT        idEx_i,
    input  wire fwdT         wbFwd_i,
    output      logic        branchTaken_o,
    output      logic [31:0] branchTarget_o,
    output      exMemT       exMem_o
);

    fwdT         memFwd;
    logic [31:0] opA;
    logic [31:0] opB;
    logic [31:0] aluB;
    logic [4:0]  shiftAmt;
    logic [31:0] aluOut;
    logic        operandsEqual;
    exMemT       exMemD;
    exMemT       exMemQ;

    // newest producer wins
    function automatic logic [31:0] forwardOp(input logic [4:0]  src,
                                              input logic [31:0] bus,
                                              input fwdT         memRec,
                                              input fwdT         wbRec);
        if (src != 5'd0 && memRec.regWrite && memRec.dst == src) begin
            return memRec.value;
        end else if (src != 5'd0 && wbRec.regWrite && wbRec.dst == src) begin
            return wbRec.value;
        end
        return bus;
    endfunction

    // load results are not ready in memory stage
    assign memFwd = '{
        regWrite: exMemQ.regWrite & ~exMemQ.memRead,
        dst:      exMemQ.dst,
        value:    exMemQ.aluOut
    };

    assign opA = forwardOp(idEx_i.rs, idEx_i.busA, memFwd, wbFwd_i);
    assign opB = forwardOp(idEx_i.rt, idEx_i.busB, memFwd, wbFwd_i);
    assign aluB = idEx_i.ctrl.aluSrcImm ? idEx_i.imm32 : opB;
    assign shiftAmt = idEx_i.ctrl.shiftUsesShamt ? idEx_i.shamt : opA[4:0];

    always_comb begin
        case (idEx_i.ctrl.aluOp)
            aluSub:  aluOut = opA - aluB;
            aluAnd:  aluOut = opA & aluB;
            aluOr:   aluOut = opA | aluB;
            aluSlt:  aluOut = {31'd0, $signed(opA) < $signed(aluB)};
            aluSll:  aluOut = aluB << shiftAmt;
            aluLui:  aluOut = {idEx_i.imm32[15:0], 16'd0};
            default: aluOut = opA + aluB;     // ADDU, ADDIU, address calc
        endcase
    end

    assign operandsEqual = (opA == opB);
    assign branchTaken_o = idEx_i.valid && idEx_i.ctrl.isBranch &&
                           (idEx_i.ctrl.branchOnNe ? !operandsEqual : operandsEqual);
    assign branchTarget_o = idEx_i.pc + 32'd4 + {idEx_i.imm32[29:0], 2'b00};

    assign exMemD = '{
        valid:     idEx_i.valid,
        pc:        idEx_i.pc,
        regWrite:  idEx_i.valid & idEx_i.ctrl.regWrite,
        memRead:   idEx_i.valid & (idEx_i.ctrl.wbSel == wbMem),
        memWrite:  idEx_i.valid & idEx_i.ctrl.memWrite,
        dst:       idEx_i.dst,
        aluOut:    aluOut,
        storeData: opB
    };

    always_ff @(posedge clk) begin
        if (reset_i) begin
            exMemQ.valid <= 1'b0;
            exMemQ.regWrite <= 1'b0;
            exMemQ.memRead <= 1'b0;
            exMemQ.memWrite <= 1'b0;
        end else begin
            exMemQ <= exMemD;
        end
    end

    assign exMem_o = exMemQ;

endmodule

`default_nettype wire

// File: source/memWbStage.sv
/*
 * Memory and write-back stage
 * drives the data memory port, selects load data or ALU result into
 * MEM/WB and presents the write-back as bypass and debug trace
 */
`timescale 1ns/10ps
`default_nettype none

module memWbStage import mipsPkg::*; (
    input  wire logic        clk,
    input  wire logic        reset_i,
    input  wire exMemT       exMem_i,
    output      logic        dataEn_o,
    output      logic [3:0]  dataWen_o,
    output      logic [31:0] dataAddr_o,
    output      logic [31:0] dataWdata_o,
    input  wire logic [31:0] dataRdata_i,
    output      fwdT         wb_o,
    output      logic [31:0] debugWbPc_o,
    output      logic [3:0]  debugWbRfWen_o,
    output      logic [4:0]  debugWbRfWnum_o,
    output      logic [31:0] debugWbRfWdata_o
);

    memWbT memWbQ;
    logic  wbWrite;

    assign dataEn_o    = exMem_i.memRead | exMem_i.memWrite;
    assign dataWen_o   = {4{exMem_i.memWrite}};   // word stores only
    assign dataAddr_o  = exMem_i.aluOut;
    assign dataWdata_o = exMem_i.storeData;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            memWbQ.valid <= 1'b0;
            memWbQ.regWrite <= 1'b0;
        end else begin
            memWbQ.valid <= exMem_i.valid;
            memWbQ.pc <= exMem_i.pc;
            memWbQ.regWrite <= exMem_i.regWrite;
            memWbQ.dst <= exMem_i.dst;
            memWbQ.result <= exMem_i.memRead ? dataRdata_i : exMem_i.aluOut;
        end
    end

    assign wbWrite = memWbQ.valid & memWbQ.regWrite;

    assign wb_o = '{regWrite: wbWrite, dst: memWbQ.dst, value: memWbQ.result};

    assign debugWbPc_o      = memWbQ.pc;
    assign debugWbRfWen_o   = {4{wbWrite}};
    assign debugWbRfWnum_o  = memWbQ.dst;
    assign debugWbRfWdata_o = memWbQ.result;

endmodule

`default_nettype wire

// File: source/mipsCore.sv
/*
 * MIPS32 five-stage pipeline core
 * connects fetch, decode, execute and memory/write-back with the
 * register file, the memory ports and the debug trace
 */
`timescale 1ns/10ps
`default_nettype none

module mipsCore import mipsPkg::*; (
    input  wire logic        clk,
    input  wire logic        reset_i,
    output      logic [31:0] instAddr_o,
    input  wire logic [31:0] instData_i,
    output      logic        dataEn_o,
    output      logic [3:0]  dataWen_o,
    output      logic [31:0] dataAddr_o,
    output      logic [31:0] dataWdata_o,
    input  wire logic [31:0] dataRdata_i,
    output      logic [31:0] debugWbPc_o,
    output      logic [3:0]  debugWbRfWen_o,
    output      logic [4:0]  debugWbRfWnum_o,
    output      logic [31:0] debugWbRfWdata_o
);

    logic        stall;
    logic        branchTaken;
    logic [31:0] branchTarget;
    logic [4:0]  rsAddr;
    logic [4:0]  rtAddr;
    logic [31:0] rsData;
    logic [31:0] rtData;
    ifIdT        ifId;
    idExT        idEx;
    exMemT       exMem;
    fwdT         wbFwd;

    fetchStage uFetch (
        .clk(clk), .reset_i(reset_i), .stall_i(stall),
        .branchTaken_i(branchTaken), .branchTarget_i(branchTarget),
        .instAddr_o(instAddr_o), .instData_i(instData_i), .ifId_o(ifId)
    );

    regFile uRegFile (
        .clk(clk), .reset_i(reset_i), .wb_i(wbFwd),
        .rsAddr_i(rsAddr), .rtAddr_i(rtAddr), .rsData_o(rsData), .rtData_o(rtData)
    );

    decodeStage uDecode (
        .clk(clk), .reset_i(reset_i), .ifId_i(ifId),
        .rsAddr_o(rsAddr), .rtAddr_o(rtAddr), .rsData_i(rsData), .rtData_i(rtData),
        .branchTaken_i(branchTaken), .stall_o(stall), .idEx_o(idEx)
    );

    executeStage uExecute (
        .clk(clk), .reset_i(reset_i), .idEx_i(idEx), .wbFwd_i(wbFwd),
        .branchTaken_o(branchTaken), .branchTarget_o(branchTarget), .exMem_o(exMem)
    );

    memWbStage uMemWb (
        .clk(clk), .reset_i(reset_i), .exMem_i(exMem),
        .dataEn_o(dataEn_o), .dataWen_o(dataWen_o), .dataAddr_o(dataAddr_o),
        .dataWdata_o(dataWdata_o), .dataRdata_i(dataRdata_i), .wb_o(wbFwd),
        .debugWbPc_o(debugWbPc_o), .debugWbRfWen_o(debugWbRfWen_o),
        .debugWbRfWnum_o(debugWbRfWnum_o), .debugWbRfWdata_o(debugWbRfWdata_o)
    );

endmodule

`default_nettype wire

// File: bench/memoryModel.sv
/*
 * Memory model for the core testbench
 * instruction ROM holding the test program at the reset vector and a
 * 256-word byte-enabled data RAM, both read combinationally
 */
`timescale 1ns/10ps
`default_nettype none

module memoryModel import mipsPkg::*; #(
    parameter int progLen = 35
) (
    input  wire logic        clk,
    input  wire logic [31:0] instAddr_i,
    output      logic [31:0] instData_o,
    input  wire logic        dataEn_i,
    input  wire logic [3:0]  dataWen_i,
    input  wire logic [31:0] dataAddr_i,
    input  wire logic [31:0] dataWdata_i,
    output      logic [31:0] dataRdata_o
);

    logic [31:0] rom [64];
    logic [31:0] ram [256];
    logic [31:0] instIdx;
    logic [15:0] seedImm [4];
    logic [31:0] rnd;
    integer      seed;

    function automatic logic [31:0] rType(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [4:0] sa,
                                          input logic [5:0] fn);
        return {opSpecial, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    initial begin
        seed = 32'h2166;
        for (int i = 0; i < 4; i++) begin
            rnd = $random(seed);
            seedImm[i] = rnd[15:0];
        end
        for (int i = 0; i < 256; i++) begin
            ram[i] = {8'hDA, 8'(i), 8'(~i), 8'h3C};  // word index in two bytes
        end
        rom[0]  = iType(opLui, 5'd0, 5'd1, seedImm[0]);
        rom[1]  = iType(opOri, 5'd1, 5'd1, seedImm[1]);
        rom[2]  = iType(opLui, 5'd0, 5'd2, seedImm[2]);
        rom[3]  = iType(opOri, 5'd2, 5'd2, seedImm[3]);
        rom[4]  = rType(5'd1, 5'd2, 5'd3, 5'd0, fnAddu);
        rom[5]  = rType(5'd3, 5'd1, 5'd4, 5'd0, fnSubu);   // $3 from memory stage
        rom[6]  = rType(5'd3, 5'd4, 5'd5, 5'd0, fnAnd);    // $3 from write-back
        rom[7]  = rType(5'd5, 5'd3, 5'd6, 5'd0, fnOr);
        rom[8]  = rType(5'd1, 5'd2, 5'd7, 5'd0, fnSlt);
        rom[9]  = rType(5'd0, 5'd6, 5'd8, 5'd5, fnSll);
        rom[10] = iType(opAddiu, 5'd8, 5'd9, 16'hFFFD);
        rom[11] = iType(opAddiu, 5'd1, 5'd0, 16'h0007);     // write to $zero
        rom[12] = rType(5'd0, 5'd9, 5'd10, 5'd0, fnAddu);
        rom[13] = iType(opSw, 5'd0, 5'd10, 16'd16);
        rom[14] = iType(opLw, 5'd0, 5'd11, 16'd16);
        rom[15] = rType(5'd11, 5'd1, 5'd12, 5'd0, fnAddu); // load-use
        rom[16] = iType(opSw, 5'd0, 5'd12, 16'd20);
        rom[17] = iType(opLw, 5'd0, 5'd13, 16'd20);
        rom[18] = iType(opLw, 5'd0, 5'd14, 16'd24);         // untouched word
        rom[19] = iType(opBeq, 5'd1, 5'd1, 16'd2);          // taken
        rom[20] = iType(opAddiu, 5'd0, 5'd15, 16'd1);
        rom[21] = iType(opAddiu, 5'd0, 5'd16, 16'd2);
        rom[22] = iType(opBne, 5'd1, 5'd2, 16'd2);          // taken
        rom[23] = iType(opAddiu, 5'd0, 5'd17, 16'd3);
        rom[24] = iType(opAddiu, 5'd0, 5'd18, 16'd4);
        rom[25] = iType(opLw, 5'd0, 5'd19, 16'd16);
        rom[26] = iType(opBne, 5'd19, 5'd10, 16'd2);        // load feeding a branch
        rom[27] = iType(opAddiu, 5'd0, 5'd20, 16'd5);
        rom[28] = iType(opAddiu, 5'd0, 5'd21, 16'd6);
        rom[29] = iType(opBeq, 5'd1, 5'd2, 16'd2);
        rom[30] = iType(opAddiu, 5'd0, 5'd22, 16'd7);
        rom[31] = rType(5'd22, 5'd20, 5'd23, 5'd0, fnAddu);
        rom[32] = rType(5'd2, 5'd1, 5'd24, 5'd0, fnSlt);
        rom[33] = rType(5'd1, 5'd2, 5'd0, 5'd0, fnOr);
        rom[34] = rType(5'd0, 5'd0, 5'd25, 5'd0, fnOr);
    end

    assign instIdx    = (instAddr_i - resetVector) >> 2;
    assign instData_o = (instIdx < progLen) ? rom[instIdx[5:0]] : 32'd0;  // NOP past the end
    assign dataRdata_o = dataEn_i ? ram[dataAddr_i[9:2]] : 32'd0;  // read data only when enabled

    always @(posedge clk) begin
        if (dataEn_i) begin
            for (int b = 0; b < 4; b++) begin
                if (dataWen_i[b]) begin
                    ram[dataAddr_i[9:2]][8*b +: 8] <= dataWdata_i[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/mipsCoreTb.sv
/*
 * Testbench for the MIPS32 pipeline core
 * runs the program in memoryModel, steps an architectural model through
 * it and compares the write-back trace and stores against that model
 */
`timescale 1ns/10ps
`default_nettype none

module mipsCoreTb import mipsPkg::*; ();

    localparam int progLen        = 35;
    localparam int watchdogCycles = progLen * 4 + 100 + 10;  // program plus reset

    typedef struct packed {
        logic [2:0]  test;
        logic [31:0] pc;
        logic [4:0]  num;
        logic [31:0] data;
    } traceRecT;

    typedef struct packed {
        logic [2:0]  test;
        logic [31:0] addr;
        logic [31:0] data;
    } storeRecT;

    logic        clk;
    logic        reset_i;
    logic [31:0] instAddr;
    logic [31:0] instData;
    logic        dataEn;
    logic [3:0]  dataWen;
    logic [31:0] dataAddr;
    logic [31:0] dataWdata;
    logic [31:0] dataRdata;
    logic [31:0] debugWbPc;
    logic [3:0]  debugWbRfWen;
    logic [4:0]  debugWbRfWnum;
    logic [31:0] debugWbRfWdata;

    traceRecT traceQ [$];
    storeRecT storeQ [$];
    int checks [7];
    int errors [7];
    int remaining [7];
    int otherErrors;
    int totalChecks;
    int totalErrors;

    mipsCore dut_i (
        .clk(clk), .reset_i(reset_i), .instAddr_o(instAddr), .instData_i(instData),
        .dataEn_o(dataEn), .dataWen_o(dataWen), .dataAddr_o(dataAddr),
        .dataWdata_o(dataWdata), .dataRdata_i(dataRdata),
        .debugWbPc_o(debugWbPc), .debugWbRfWen_o(debugWbRfWen),
        .debugWbRfWnum_o(debugWbRfWnum), .debugWbRfWdata_o(debugWbRfWdata)
    );

    memoryModel #(.progLen(progLen)) memModel (
        .clk(clk), .instAddr_i(instAddr), .instData_o(instData),
        .dataEn_i(dataEn), .dataWen_i(dataWen), .dataAddr_i(dataAddr),
        .dataWdata_i(dataWdata), .dataRdata_o(dataRdata)
    );

    function automatic int testOf(input int idx);
        if (idx <= 10) return 2;
        if (idx <= 12) return 6;
        if (idx == 15 || idx == 25) return 4;
        if (idx <= 18) return 3;
        if (idx <= 32) return 5;
        return 6;
    endfunction

    function automatic string testName(input int t);
        case (t)
            1: return "reset state";
            2: return "ALU and immediates";
            3: return "memory";
            4: return "load-use";
            5: return "branches";
            default: return "register 0";
        endcase
    endfunction

    task automatic reportMismatch(input string sig, input logic [31:0] exp,
                                  input logic [31:0] act, input int t);
        $display("[FAIL] %0t ns: %s expected 32'h%08h, got 32'h%08h", $time, sig, exp, act);
        errors[t]++;
    endtask

    task automatic finishRecord(input int t);
        remaining[t]--;
        if (remaining[t] == 0) begin
            $display("%s: %0d checks, %0d errors", testName(t), checks[t], errors[t]);
        end
    endtask

    // architectural model, one instruction at a time with a delay slot
    task automatic buildExpected();
        logic [31:0] regs [32];
        logic [31:0] dmem [256];
        logic [31:0] pc;
        logic [31:0] npc;
        logic [31:0] nextNpc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] val;
        logic [31:0] addr;
        logic [4:0]  dst;
        logic        wr;
        logic        taken;
        int          idx;
        int          steps;
        for (int i = 0; i < 32; i++) begin
            regs[i] = 32'd0;
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i] = memModel.ram[i];
        end
        pc = resetVector;
        npc = resetVector + 32'd4;
        idx = 0;
        steps = 0;
        while (idx < progLen && steps < 4 * progLen) begin
            ins = memModel.rom[idx];
            a = regs[ins[25:21]];
            b = regs[ins[20:16]];
            imm = {{16{ins[15]}}, ins[15:0]};
            addr = a + imm;
            dst = ins[20:16];
            val = 32'd0;
            wr = 1'b0;
            taken = 1'b0;
            case (ins[31:26])
                opSpecial: begin
                    dst = ins[15:11];
                    wr = 1'b1;
                    case (ins[5:0])
                        fnAddu:  val = a + b;
                        fnSubu:  val = a - b;
                        fnAnd:   val = a & b;
                        fnOr:    val = a | b;
                        fnSlt:   val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        fnSll:   val = b << ins[10:6];
                        default: wr = 1'b0;
                    endcase
                end
                opAddiu: begin
                    wr = 1'b1;
                    val = a + imm;
                end
                opOri: begin
                    wr = 1'b1;
                    val = a | {16'd0, ins[15:0]};
                end
                opLui: begin
                    wr = 1'b1;
                    val = {ins[15:0], 16'd0};
                end
                opLw: begin
                    wr = 1'b1;
                    val = dmem[addr[9:2]];
                end
                opSw: begin
                    dmem[addr[9:2]] = b;
                    storeQ.push_back('{test: 3'(testOf(idx)), addr: addr, data: b});
                    remaining[testOf(idx)]++;
                end
                opBeq:   taken = (a == b);
                opBne:   taken = (a != b);
                default: ;
            endcase
            nextNpc = taken ? pc + 32'd4 + {imm[29:0], 2'b00} : npc + 32'd4;
            if (wr && dst != 5'd0) begin
                regs[dst] = val;
                traceQ.push_back('{test: 3'(testOf(idx)), pc: pc, num: dst, data: val});
                remaining[testOf(idx)]++;
            end
            pc = npc;
            npc = nextNpc;
            idx = int'((pc - resetVector) >> 2);
            steps++;
        end
    endtask

    task automatic checkTrace();
        traceRecT rec;
        int       t;
        if (traceQ.size() == 0) begin
            $display("unexpected write-back to register %0d at pc %08h, none was expected",
                     debugWbRfWnum, debugWbPc);
            otherErrors++;
        end else begin
            rec = traceQ.pop_front();
            t = rec.test;
            checks[t] += 4;
            assert (debugWbRfWen == 4'hF)
                else reportMismatch("debugWbRfWen_o", 32'hF, {28'd0, debugWbRfWen}, t);
            assert (debugWbPc == rec.pc)
                else reportMismatch("debugWbPc_o", rec.pc, debugWbPc, t);
            assert (debugWbRfWnum == rec.num)
                else reportMismatch("debugWbRfWnum_o", {27'd0, rec.num}, {27'd0, debugWbRfWnum}, t);
            assert (debugWbRfWdata == rec.data)
                else reportMismatch("debugWbRfWdata_o", rec.data, debugWbRfWdata, t);
            finishRecord(t);
        end
    endtask

    task automatic checkStore();
        storeRecT rec;
        int       t;
        if (storeQ.size() == 0) begin
            $display("unexpected store to address %08h, none was expected", dataAddr);
            otherErrors++;
        end else begin
            rec = storeQ.pop_front();
            t = rec.test;
            checks[t] += 3;
            assert (dataWen == 4'hF)
                else reportMismatch("dataWen_o", 32'hF, {28'd0, dataWen}, t);
            assert (dataAddr == rec.addr)
                else reportMismatch("dataAddr_o", rec.addr, dataAddr, t);
            assert (dataWdata == rec.data)
                else reportMismatch("dataWdata_o", rec.data, dataWdata, t);
            finishRecord(t);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // outputs are sampled half a cycle after the driving edge
    always @(negedge clk) begin
        if (!reset_i && debugWbRfWen != 4'd0) begin
            checkTrace();
        end
        if (!reset_i && dataWen != 4'd0) begin
            checkStore();
        end
    end

    initial begin
        repeat (watchdogCycles) @(posedge clk);
        $display("trace did not complete: %0d write-backs and %0d stores missing after %0d cycles",
                 traceQ.size(), storeQ.size(), watchdogCycles);
        $display("Test failed");
        $finish;
    end

    initial begin
        reset_i = 1'b1;
        otherErrors = 0;
        #1;
        buildExpected();
        @(posedge clk);     // first edge clears the valid bits
        for (int c = 0; c < 9; c++) begin
            @(negedge clk);
            checks[1] += 3;
            assert (dataEn == 1'b0) else reportMismatch("dataEn_o", 32'd0, {31'd0, dataEn}, 1);
            assert (dataWen == 4'd0) else reportMismatch("dataWen_o", 32'd0, {28'd0, dataWen}, 1);
            assert (debugWbRfWen == 4'd0)
                else reportMismatch("debugWbRfWen_o", 32'd0, {28'd0, debugWbRfWen}, 1);
            @(posedge clk);
        end
        reset_i <= 1'b0;
        @(negedge clk);
        checks[1]++;
        assert (instAddr == resetVector) else reportMismatch("instAddr_o", resetVector, instAddr, 1);
        $display("%s: %0d checks, %0d errors", testName(1), checks[1], errors[1]);

        while (traceQ.size() != 0 || storeQ.size() != 0) begin
            @(negedge clk);
        end
        repeat (8) @(negedge clk);     // catch duplicated records

        totalChecks = 0;
        totalErrors = otherErrors;
        for (int t = 1; t <= 6; t++) begin
            totalChecks += checks[t];
            totalErrors += errors[t];
        end
        $display("tests: 6, checks: %0d, errors: %0d", totalChecks, totalErrors);
        if (totalErrors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: mipsCore.f
source/mipsPkg.sv
source/fetchStage.sv
source/regFile.sv
source/decodeStage.sv
source/executeStage.sv
source/memWbStage.sv
source/mipsCore.sv
bench/memoryModel.sv
bench/mipsCoreTb.sv
